// ==== all.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/rv_exec_core.sv
verification/tb_rv_exec_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_rv_exec_core
FLIST     = all.f

SRCS = $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== verification/tb_rv_exec_core.sv ====
`timescale 1ns/1ps

module tb_rv_exec_core
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
;

	logic       clk;
	logic       rst;
	logic       req;
	word_t      instr;
	word_t      pc;
	logic       ack;
	word_t      result;
	reg_idx_t   rd;
	logic       wb_en;
	logic       taken;
	word_t      target;
	mem_op_t    mem_op;
	muldiv_op_t muldiv_op;

	// one slot per case for stimulus and expected values
	string       names[$];
	logic [31:0] t_instr[$];
	logic [31:0] t_pc[$];
	logic [31:0] t_res[$];
	logic [31:0] t_chk_res[$];	// 0 where the result has no defined value
	int          t_rd[$];	// -1 where the format has no rd field
	logic [31:0] t_we[$];
	logic [31:0] t_taken[$];
	logic [31:0] t_target[$];
	logic [31:0] t_mem[$];
	logic [31:0] t_md[$];

	int seed = 32'h4c57e381;
	int cycles = 0;

	rv_exec_core DUT (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_req       (req),
		.i_instr     (instr),
		.i_pc        (pc),
		.o_ack       (ack),
		.o_result    (result),
		.o_rd        (rd),
		.o_wb_en     (wb_en),
		.o_taken     (taken),
		.o_target    (target),
		.o_mem_op    (mem_op),
		.o_muldiv_op (muldiv_op)
	);

	always #50 clk = ~clk;	// 100 ns period

	// run limit of 10 cycles per case against a worst case of 8
	always @(posedge clk) begin
		cycles++;
		if (cycles > names.size() * 10 + 20) begin
			$display("timeout after %0d cycles, the DUT never finished the handshake", cycles);
			$display("** FAIL **");
			$fatal(1, "run limit reached");
		end
	end

	task automatic check(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
			$display("** FAIL **");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic add_case(input string name, input logic [31:0] ins, input logic [31:0] addr,
		input logic [31:0] res, input logic [31:0] chk_res, input int dest,
		input logic [31:0] we, input logic [31:0] tk, input logic [31:0] tgt,
		input logic [31:0] mem, input logic [31:0] md);
		names.push_back(name);
		t_instr.push_back(ins);
		t_pc.push_back(addr);
		t_res.push_back(res);
		t_chk_res.push_back(chk_res);
		t_rd.push_back(dest);
		t_we.push_back(we);
		t_taken.push_back(tk);
		t_target.push_back(tgt);
		t_mem.push_back(mem);
		t_md.push_back(md);
	endtask

	// four-phase transfer
	// entered and left 1 ns after a rising edge
	task automatic run_case(input int idx);
		int    edges;
		int    gap;
		word_t held;
		instr = t_instr[idx];
		pc    = t_pc[idx];
		req   = 1'b1;
		edges = 0;
		do begin
			@(posedge clk);
			#1;
			edges++;
		end while (!ack);
		check(names[idx], "ack latency", 2, edges);	// latch edge then publish edge
		if (t_chk_res[idx] != 0)
			check(names[idx], "result", t_res[idx], result);
		if (t_rd[idx] >= 0)
			check(names[idx], "rd", t_rd[idx], 32'(rd));
		check(names[idx], "wb_en", t_we[idx], 32'(wb_en));
		check(names[idx], "taken", t_taken[idx], 32'(taken));
		check(names[idx], "target", t_target[idx], target);
		check(names[idx], "mem_op", t_mem[idx], 32'(mem_op));
		check(names[idx], "muldiv_op", t_md[idx], 32'(muldiv_op));
		held = result;
		repeat (idx % 3) begin	// req kept high as back-pressure
			@(posedge clk);
			#1;
			check(names[idx], "ack held", 1, 32'(ack));
			check(names[idx], "result held", held, result);
		end
		req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (ack);
		gap = $random(seed) & 3;	// idle 0..3 cycles
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk   = 1'b0;
		rst   = 1'b1;
		req   = 1'b0;
		instr = '0;
		pc    = '0;

		// register setup x1 = 0xff, x2 = -3 and x3 = 0x12345678
		add_case("addi x1", 32'h0FF00093, 32'h100, 32'h0FF, 1, 1, 1, 0, 32'h104, 'h0, 'h0);
		add_case("addi x2", 32'hFFD00113, 32'h104, 32'hFFFFFFFD, 1, 2, 1, 0, 32'h108, 'h0, 'h0);
		add_case("lui x3", 32'h123451B7, 32'h108, 32'h12345000, 1, 3, 1, 0, 32'h10C, 'h0, 'h0);
		add_case("addi x3", 32'h67818193, 32'h10C, 32'h12345678, 1, 3, 1, 0, 32'h110, 'h0, 'h0);
		add_case("add", 32'h00208233, 32'h110, 32'h0FC, 1, 4, 1, 0, 32'h114, 'h0, 'h0);
		add_case("sub", 32'h402082B3, 32'h114, 32'h102, 1, 5, 1, 0, 32'h118, 'h0, 'h0);
		add_case("and", 32'h0011F333, 32'h118, 32'h078, 1, 6, 1, 0, 32'h11C, 'h0, 'h0);
		add_case("or", 32'h0011E3B3, 32'h11C, 32'h123456FF, 1, 7, 1, 0, 32'h120, 'h0, 'h0);
		add_case("xor", 32'h0011C433, 32'h120, 32'h12345687, 1, 8, 1, 0, 32'h124, 'h0, 'h0);
		add_case("slt", 32'h001124B3, 32'h124, 32'h1, 1, 9, 1, 0, 32'h128, 'h0, 'h0);
		add_case("sltu", 32'h00113533, 32'h128, 32'h0, 1, 10, 1, 0, 32'h12C, 'h0, 'h0);
		add_case("slli", 32'h00409593, 32'h12C, 32'hFF0, 1, 11, 1, 0, 32'h130, 'h0, 'h0);
		add_case("srli", 32'h0081D613, 32'h130, 32'h00123456, 1, 12, 1, 0, 32'h134, 'h0, 'h0);
		add_case("srai neg", 32'h40115693, 32'h134, 32'hFFFFFFFE, 1, 13, 1, 0, 32'h138, 'h0, 'h0);
		add_case("sra x4", 32'h40415733, 32'h138, 32'hFFFFFFFF, 1, 14, 1, 0, 32'h13C, 'h0, 'h0);
		add_case("srl x4", 32'h004157B3, 32'h13C, 32'h0000000F, 1, 15, 1, 0, 32'h140, 'h0, 'h0);
		// branches report pc+imm as target either way
		add_case("beq t", 32'h00108863, 32'h140, 32'h0, 0, -1, 0, 1, 32'h150, 'h0, 'h0);
		add_case("beq nt", 32'h00208863, 32'h144, 32'h0, 0, -1, 0, 0, 32'h154, 'h0, 'h0);
		add_case("bne t", 32'h00209863, 32'h148, 32'h0, 0, -1, 0, 1, 32'h158, 'h0, 'h0);
		add_case("bne nt", 32'h00109863, 32'h14C, 32'h0, 0, -1, 0, 0, 32'h15C, 'h0, 'h0);
		add_case("blt t back", 32'hFE114CE3, 32'h150, 32'h0, 0, -1, 0, 1, 32'h148, 'h0, 'h0);
		add_case("blt nt", 32'h0020C863, 32'h154, 32'h0, 0, -1, 0, 0, 32'h164, 'h0, 'h0);
		add_case("bge t", 32'h0020D863, 32'h158, 32'h0, 0, -1, 0, 1, 32'h168, 'h0, 'h0);
		add_case("bge nt", 32'h00115863, 32'h15C, 32'h0, 0, -1, 0, 0, 32'h16C, 'h0, 'h0);
		add_case("bltu t", 32'h0020E863, 32'h160, 32'h0, 0, -1, 0, 1, 32'h170, 'h0, 'h0);
		add_case("bltu nt", 32'h00116863, 32'h164, 32'h0, 0, -1, 0, 0, 32'h174, 'h0, 'h0);
		add_case("bgeu t", 32'h00117863, 32'h168, 32'h0, 0, -1, 0, 1, 32'h178, 'h0, 'h0);
		add_case("bgeu nt", 32'h0020F863, 32'h16C, 32'h0, 0, -1, 0, 0, 32'h17C, 'h0, 'h0);
		add_case("jal", 32'h0200086F, 32'h170, 32'h174, 1, 16, 1, 1, 32'h190, 'h0, 'h0);
		add_case("jalr odd", 32'h003188E7, 32'h174, 32'h178, 1, 17, 1, 1, 32'h1234567A, 'h0, 'h0);
		add_case("auipc", 32'h00001917, 32'h178, 32'h1178, 1, 18, 1, 0, 32'h17C, 'h0, 'h0);
		// memory ops only report the address
		add_case("lw", 32'h00822983, 32'h17C, 32'h104, 1, 19, 0, 0, 32'h180, 'h7, 'h0);
		add_case("lbu", 32'hFFF24A03, 32'h180, 32'h0FB, 1, 20, 0, 0, 32'h184, 'h4, 'h0);
		add_case("sh", 32'h00121323, 32'h184, 32'h102, 1, -1, 0, 0, 32'h188, 'hB, 'h0);
		add_case("sb", 32'hFE218E23, 32'h188, 32'h12345674, 1, -1, 0, 0, 32'h18C, 'hD, 'h0);
		add_case("mul", 32'h02208AB3, 32'h18C, 32'h0, 0, 21, 0, 0, 32'h190, 'h0, 'h3);
		add_case("divu", 32'h0220DB33, 32'h190, 32'h0, 0, 22, 0, 0, 32'h194, 'h0, 'hB);
		// mul left x21 at 0
		add_case("read x21", 32'h000A8B93, 32'h194, 32'h0, 1, 23, 1, 0, 32'h198, 'h0, 'h0);
		add_case("write x0", 32'h00708013, 32'h198, 32'h106, 1, 0, 1, 0, 32'h19C, 'h0, 'h0);
		add_case("read x0", 32'h00000C33, 32'h19C, 32'h0, 1, 24, 1, 0, 32'h1A0, 'h0, 'h0);

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		check("reset", "ack", 0, 32'(ack));
		check("reset", "wb_en", 0, 32'(wb_en));
		check("reset", "taken", 0, 32'(taken));

		for (int i = 0; i < names.size(); i++)
			run_case(i);

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== hdl/rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_req,	// four-phase request
	input  word_t      i_instr,
	input  word_t      i_pc,
	output logic       o_ack,
	output word_t      o_result,	// wb value, or address for load/store
	output reg_idx_t   o_rd,
	output logic       o_wb_en,
	output logic       o_taken,
	output word_t      o_target,	// redirect target, else pc+4
	output mem_op_t    o_mem_op,
	output muldiv_op_t o_muldiv_op
);

	exec_state_e state;
	word_t       r_instr;	// latched request
	word_t       r_pc;

	b_sel_t     dec_b_sel;
	logic       dec_we;
	wb_sel_t    dec_fn;
	alu_fn_t    dec_alu_fn;
	logic       dec_j, dec_jr, dec_bneq, dec_btype, dec_lui, dec_auipc;
	mem_op_t    dec_mem_op;
	muldiv_op_t dec_muldiv_op;
	pc_sel_t    dec_pc_sel;

	word_t imm, rs1_data, rs2_data, op_a, op_b, alu_res;
	word_t pc_plus4, tgt_sum, tgt_next, wb_val;
	logic  alu_cmp, taken, wb_en;

	instr_decoder u_dec (
		.i_op        (opcode_e'(r_instr[6:0])),
		.i_funct3    (r_instr[14:12]),
		.i_funct7    (r_instr[31:25]),
		.i_instr_30  (r_instr[30]),
		.o_b_sel     (dec_b_sel),
		.o_we        (dec_we),
		.o_fn        (dec_fn),
		.o_alu_fn    (dec_alu_fn),
		.o_j         (dec_j),
		.o_jr        (dec_jr),
		.o_bneq      (dec_bneq),
		.o_btype     (dec_btype),
		.o_lui       (dec_lui),
		.o_auipc     (dec_auipc),
		.o_mem_op    (dec_mem_op),
		.o_muldiv_op (dec_muldiv_op),
		.o_pc_sel    (dec_pc_sel)
	);

	imm_gen u_imm (.i_instr(r_instr), .o_imm(imm));

	reg_file u_rf (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_rs1      (r_instr[19:15]),
		.i_rs2      (r_instr[24:20]),
		.i_we       (state == EXEC && wb_en),	// single write per request
		.i_rd       (r_instr[11:7]),
		.i_wdata    (wb_val),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	// lui adds to zero and auipc to pc, so the alu covers both
	assign op_a = dec_lui ? '0 : (dec_auipc ? r_pc : rs1_data);

	always_comb begin
		case (dec_b_sel)
			B_IMM:   op_b = imm;
			B_SHAMT: op_b = word_t'(imm[4:0]);
			default: op_b = rs2_data;	// B_REG
		endcase
	end

	alu u_alu (.i_a(op_a), .i_b(op_b), .i_fn(dec_alu_fn), .o_result(alu_res), .o_cmp_true(alu_cmp));

	assign pc_plus4 = r_pc + 32'd4;
	assign tgt_sum  = (dec_pc_sel[0] ? rs1_data : r_pc) + imm;	// jalr is rs1 based
	assign tgt_next = dec_pc_sel[1] ? {tgt_sum[31:1], dec_pc_sel[0] ? 1'b0 : tgt_sum[0]}
		: pc_plus4;
	assign taken    = dec_j | dec_jr | (dec_btype & (alu_cmp ^ dec_bneq));

	// jumps link pc+4, the rest take the alu result
	assign wb_val = (dec_fn == WB_PC4) ? pc_plus4 : alu_res;
	assign wb_en  = dec_we & (dec_fn != WB_LOAD) & (dec_fn != WB_MULDIV);	// no memory or multiplier

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state   <= IDLE;
			o_ack   <= 1'b0;
			o_wb_en <= 1'b0;
			o_taken <= 1'b0;
		end else begin
			case (state)
				IDLE: if (i_req) state <= EXEC;
				EXEC: begin	// datapath settled, publish
					state   <= ACK;
					o_ack   <= 1'b1;
					o_wb_en <= wb_en;
					o_taken <= taken;
				end
				ACK: if (!i_req) begin	// held req stalls here
					state <= IDLE;
					o_ack <= 1'b0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == IDLE && i_req) begin
			r_instr <= i_instr;
			r_pc    <= i_pc;
		end
		if (state == EXEC) begin
			o_result    <= wb_val;
			o_rd        <= r_instr[11:7];
			o_target    <= tgt_next;
			o_mem_op    <= dec_mem_op;
			o_muldiv_op <= dec_muldiv_op;
		end
	end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module reg_file
	import rv_isa_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst,
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	input  logic     i_we,
	input  reg_idx_t i_rd,
	input  word_t    i_wdata,
	output word_t    o_rs1_data,
	output word_t    o_rs2_data
);

	word_t regs [`RV_NREGS];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < `RV_NREGS; i++)
				regs[i] <= '0;
		end else if (i_we && i_rd != '0) begin	// x0 writes dropped
			regs[i_rd] <= i_wdata;
		end
	end

	// async read, x0 always zero
	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  word_t   i_a,
	input  word_t   i_b,
	input  alu_fn_t i_fn,
	output word_t   o_result,
	output logic    o_cmp_true	// branch condition, before bneq
);

	logic       eq;
	logic       lt_s;
	logic       lt_u;
	logic [4:0] shamt;

	assign eq    = (i_a == i_b);
	assign lt_s  = $signed(i_a) < $signed(i_b);
	assign lt_u  = i_a < i_b;
	assign shamt = i_b[4:0];	// upper bits ignored

	always_comb begin
		case (i_fn)
			ALU_ADD:  o_result = i_a + i_b;
			ALU_SUB:  o_result = i_a - i_b;
			ALU_SLL:  o_result = i_a << shamt;
			ALU_SRL:  o_result = i_a >> shamt;
			ALU_SRA:  o_result = $signed(i_a) >>> shamt;	// sign fill
			ALU_SLT:  o_result = word_t'(lt_s);
			ALU_SLTU: o_result = word_t'(lt_u);
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_OR:   o_result = i_a | i_b;
			ALU_AND:  o_result = i_a & i_b;
			ALU_SGE:  o_result = word_t'(~lt_s);
			ALU_SGEU: o_result = word_t'(~lt_u);
			default:  o_result = '0;
		endcase
	end

	// beq/bne share the sub code
	always_comb begin
		case (i_fn)
			ALU_SUB:  o_cmp_true = eq;
			ALU_SLT:  o_cmp_true = lt_s;
			ALU_SLTU: o_cmp_true = lt_u;
			ALU_SGE:  o_cmp_true = ~lt_s;
			ALU_SGEU: o_cmp_true = ~lt_u;
			default:  o_cmp_true = 1'b0;
		endcase
	end

endmodule

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen
	import rv_isa_pkg::*;
(
	input  word_t i_instr,
	output word_t o_imm
);

	opcode_e op;

	assign op = opcode_e'(i_instr[6:0]);

	// instr[31] is the sign bit in every format
	always_comb begin
		case (op)
			OP_IMM, LOAD, JALR:	// I
				o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
			STORE:	// S, split around rd
				o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			BRANCH:	// B, bit 0 implied zero
				o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
					i_instr[30:25], i_instr[11:8], 1'b0};
			LUI, AUIPC:	// U
				o_imm = {i_instr[31:12], 12'b0};
			JAL:	// J
				o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
					i_instr[20], i_instr[30:21], 1'b0};
			default:
				o_imm = '0;	// reg-reg and unknown
		endcase
	end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  opcode_e    i_op,
	input  funct3_t    i_funct3,
	input  funct7_t    i_funct7,
	input  logic       i_instr_30,	// instr[30]
	output b_sel_t     o_b_sel,
	output logic       o_we,
	output wb_sel_t    o_fn,
	output alu_fn_t    o_alu_fn,
	output logic       o_j,
	output logic       o_jr,
	output logic       o_bneq,	// invert the compare
	output logic       o_btype,
	output logic       o_lui,
	output logic       o_auipc,
	output mem_op_t    o_mem_op,
	output muldiv_op_t o_muldiv_op,
	output pc_sel_t    o_pc_sel
);

	logic [7:0] f3;	// one-hot funct3
	logic rtype, itype, btype, jtype, jrtype, ltype, stype, utype, autype;
	logic m_ext;	// funct7 == 0000001
	logic alu_r;	// plain reg-reg alu op
	logic muldiv;
	logic is_sub, is_sll, is_slt, is_sltu, is_xor, is_srl, is_sra, is_or, is_and;
	logic is_addi, is_slti, is_sltiu, is_xori, is_ori, is_andi, is_slli, is_srli, is_srai;
	logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
	logic is_jalr;
	logic is_mul, is_mulh, is_mulhsu, is_mulhu, is_div, is_divu, is_rem, is_remu;
	logic is_lb, is_lh, is_lw, is_lbu, is_lhu, is_sb, is_sh, is_sw;

	assign f3 = 8'b1 << i_funct3;
	assign m_ext = (i_funct7 == 7'b0000001);

	assign rtype  = (i_op == OP);
	assign itype  = (i_op == OP_IMM);
	assign btype  = (i_op == BRANCH);
	assign jtype  = (i_op == JAL);
	assign jrtype = (i_op == JALR);
	assign ltype  = (i_op == LOAD);
	assign stype  = (i_op == STORE);
	assign utype  = (i_op == LUI);
	assign autype = (i_op == AUIPC);

	assign alu_r  = rtype & ~m_ext;	// keep mul/div out of the base decode
	assign muldiv = rtype & m_ext;

	// add is 0000 and needs no term of its own
	assign is_sub  = alu_r &  i_instr_30 & f3[0];
	assign is_sll  = alu_r & ~i_instr_30 & f3[1];
	assign is_slt  = alu_r & ~i_instr_30 & f3[2];
	assign is_sltu = alu_r & ~i_instr_30 & f3[3];
	assign is_xor  = alu_r & ~i_instr_30 & f3[4];
	assign is_srl  = alu_r & ~i_instr_30 & f3[5];
	assign is_sra  = alu_r &  i_instr_30 & f3[5];
	assign is_or   = alu_r & ~i_instr_30 & f3[6];
	assign is_and  = alu_r & ~i_instr_30 & f3[7];

	assign is_addi  = itype & f3[0];
	assign is_slti  = itype & f3[2];
	assign is_sltiu = itype & f3[3];
	assign is_xori  = itype & f3[4];
	assign is_ori   = itype & f3[6];
	assign is_andi  = itype & f3[7];
	assign is_slli  = itype & ~i_instr_30 & f3[1];
	assign is_srli  = itype & ~i_instr_30 & f3[5];
	assign is_srai  = itype &  i_instr_30 & f3[5];	// imm[10] set

	assign is_beq  = btype & f3[0];
	assign is_bne  = btype & f3[1];
	assign is_blt  = btype & f3[4];
	assign is_bge  = btype & f3[5];
	assign is_bltu = btype & f3[6];
	assign is_bgeu = btype & f3[7];
	assign is_jalr = jrtype & f3[0];

	assign is_mul    = muldiv & f3[0];
	assign is_mulh   = muldiv & f3[1];
	assign is_mulhsu = muldiv & f3[2];
	assign is_mulhu  = muldiv & f3[3];
	assign is_div    = muldiv & f3[4];
	assign is_divu   = muldiv & f3[5];
	assign is_rem    = muldiv & f3[6];
	assign is_remu   = muldiv & f3[7];

	assign is_lb  = ltype & f3[0];
	assign is_lh  = ltype & f3[1];
	assign is_lw  = ltype & f3[2];
	assign is_lbu = ltype & f3[4];
	assign is_lhu = ltype & f3[5];
	assign is_sb  = stype & f3[0];
	assign is_sh  = stype & f3[1];
	assign is_sw  = stype & f3[2];

	// size 11 word, 01 half, 10 byte
	assign o_mem_op[0] = is_sw | is_sh | is_sb | is_lw | is_lh | is_lb;	// signed
	assign o_mem_op[1] = is_sw | is_sh | is_lw | is_lh | is_lhu;
	assign o_mem_op[2] = is_sw | is_sb | is_lw | is_lb | is_lbu;
	assign o_mem_op[3] = is_sw | is_sh | is_sb;	// store

	assign o_alu_fn[0] = is_sll | is_slli | is_sltu | is_sltiu | is_srl | is_srli
		| is_and | is_andi | is_sra | is_srai | is_bltu | is_bge;
	assign o_alu_fn[1] = is_slt | is_slti | is_sltu | is_sltiu | is_or | is_ori
		| is_and | is_andi | is_blt | is_bltu | is_bgeu;
	assign o_alu_fn[2] = is_xor | is_xori | is_srl | is_srli | is_or | is_ori
		| is_and | is_andi | is_sra | is_srai;
	assign o_alu_fn[3] = is_sub | is_sra | is_srai | is_beq | is_bne | is_bge | is_bgeu;

	// 0011 mul, 0101 mulh, 0111 mulhu, 0110 mulhsu, 1x01 div/rem, 1x11 unsigned
	assign o_muldiv_op[0] = is_mul | is_mulh | is_mulhu | is_div | is_divu | is_rem | is_remu;
	assign o_muldiv_op[1] = is_mul | is_mulhu | is_mulhsu | is_divu | is_remu;
	assign o_muldiv_op[2] = is_mulh | is_mulhu | is_mulhsu | is_rem | is_remu;
	assign o_muldiv_op[3] = is_div | is_divu | is_rem | is_remu;

	// b from the immediate for reg-imm, address and upper-immediate forms
	assign o_b_sel[0] = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi
		| is_jalr | ltype | stype | utype | autype;
	assign o_b_sel[1] = is_slli | is_srli | is_srai;	// shamt

	assign o_we     = rtype | itype | jtype | is_jalr | ltype | utype | autype;
	assign o_pc_sel = {btype | jtype | is_jalr, is_jalr};
	assign o_bneq   = is_bne;
	assign o_btype  = btype;
	assign o_j      = jtype;
	assign o_jr     = is_jalr;
	assign o_lui    = utype;
	assign o_auipc  = autype;

	always_comb begin
		o_fn = WB_ALU;
		if (jtype | is_jalr)
			o_fn = WB_PC4;	// link address
		if (muldiv)
			o_fn = WB_MULDIV;
		if (utype)
			o_fn = WB_IMM;
		if (autype)
			o_fn = WB_AUIPC;
		if (ltype)
			o_fn = WB_LOAD;
	end

endmodule

// ==== hdl/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

	// alu code is {instr[30], funct3}
	// branch compares share the sub and slt slots
	typedef logic [3:0] alu_fn_t;
	localparam alu_fn_t ALU_ADD  = 4'b0000;
	localparam alu_fn_t ALU_SLL  = 4'b0001;
	localparam alu_fn_t ALU_SLT  = 4'b0010;	// also blt
	localparam alu_fn_t ALU_SLTU = 4'b0011;	// also bltu
	localparam alu_fn_t ALU_XOR  = 4'b0100;
	localparam alu_fn_t ALU_SRL  = 4'b0101;
	localparam alu_fn_t ALU_OR   = 4'b0110;
	localparam alu_fn_t ALU_AND  = 4'b0111;
	localparam alu_fn_t ALU_SUB  = 4'b1000;	// also beq/bne
	localparam alu_fn_t ALU_SGE  = 4'b1001;	// bge
	localparam alu_fn_t ALU_SGEU = 4'b1010;	// bgeu
	localparam alu_fn_t ALU_SRA  = 4'b1101;

	typedef logic [3:0] mem_op_t;	// [3] store, [2:1] size, [0] signed
	typedef logic [3:0] muldiv_op_t;	// [3] div/rem, [2] high half or rem, [1:0] sign
	typedef logic [1:0] pc_sel_t;	// [1] redirect, [0] register based

	// writeback source
	typedef logic [2:0] wb_sel_t;
	localparam wb_sel_t WB_ALU    = 3'b000;
	localparam wb_sel_t WB_PC4    = 3'b001;
	localparam wb_sel_t WB_MULDIV = 3'b010;
	localparam wb_sel_t WB_IMM    = 3'b011;
	localparam wb_sel_t WB_AUIPC  = 3'b100;
	localparam wb_sel_t WB_LOAD   = 3'b111;

	// alu operand b source
	typedef logic [1:0] b_sel_t;
	localparam b_sel_t B_REG   = 2'b00;
	localparam b_sel_t B_IMM   = 2'b01;
	localparam b_sel_t B_SHAMT = 2'b10;

	typedef enum logic [1:0] {IDLE, EXEC, ACK} exec_state_e;	// req/ack handshake

endpackage

// ==== hdl/rv_isa_pkg.sv ====
`include "rv_cfg.svh"

package rv_isa_pkg;

	typedef logic [`RV_XLEN-1:0]   word_t;	// instruction or data word
	typedef logic [`RV_REG_AW-1:0] reg_idx_t;	// register file index
	typedef logic [2:0]            funct3_t;	// instr[14:12]
	typedef logic [6:0]            funct7_t;	// instr[31:25]

	// major opcodes, instr[6:0]
	// anything outside this list decodes to no operation
	typedef enum logic [6:0] {
		OP     = 7'b0110011,	// reg-reg alu and mul/div
		OP_IMM = 7'b0010011,	// reg-imm alu
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_e;

endpackage

// ==== hdl/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// integer datapath width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// rs1/rs2/rd field width
`define RV_REG_AW 5

`endif
